// ==== hw/regPkg.sv ====
package regPkg;

	// One data word as held in a register and carried on the load bus.
	typedef logic [15:0] word_t;

	// Selects one of the registers.
	typedef logic [3:0] regIdx_t;

	localparam int NumRegs = 16;

endpackage

// ==== hw/aluPkg.sv ====
package aluPkg;

	typedef logic [2:0] opcode_t;

	localparam opcode_t OpAdd = 3'd0; // Rdest + Rsrc, wraps at 16 bits.
	localparam opcode_t OpSub = 3'd1; // Rdest - Rsrc, wraps at 16 bits.
	localparam opcode_t OpAnd = 3'd2;
	localparam opcode_t OpOr  = 3'd3;
	localparam opcode_t OpXor = 3'd4;
	localparam opcode_t OpMov = 3'd5; // Rdest takes Rsrc.

	// Codes 6 and 7 complete without writing anything.

endpackage

// ==== hw/regPortIf.sv ====
`timescale 1ns/1ps

interface regPortIf;

	logic             req;
	logic             gnt;
	regPkg::regIdx_t  rdestLoc;
	regPkg::regIdx_t  rsrcLoc;
	logic             we;
	regPkg::word_t    load;
	regPkg::word_t    rdestData;
	regPkg::word_t    rsrcData;

	modport requester (
		output req, rdestLoc, rsrcLoc, we, load,
		input  gnt, rdestData, rsrcData
	);

	modport arbiter (
		input  req, rdestLoc, rsrcLoc, we, load,
		output gnt, rdestData, rsrcData
	);

	// The register file always accepts, so it has no use for req and gnt.
	modport regFile (
		input  rdestLoc, rsrcLoc, we, load,
		output rdestData, rsrcData
	);

endinterface

// ==== hw/RegFile.sv ====
`timescale 1ns/1ps

module RegFile #(
	parameter regPkg::regIdx_t keyReg = 4'd9
) (
	input  logic          Clk,
	input  logic          rst,
	regPortIf.regFile     port,
	output regPkg::word_t KeyCode
);

	regPkg::word_t                 regs [regPkg::NumRegs];
	logic [regPkg::NumRegs-1:0]    wrEn;

	// One-hot write decode of the Rdest location.
	always_comb begin
		wrEn = '0;
		if (port.we) begin
			wrEn[port.rdestLoc] = 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		for (int i = 0; i < regPkg::NumRegs; i++) begin
			if (!rst) begin
				regs[i] <= '0;
			end else if (wrEn[i]) begin
				regs[i] <= port.load;
			end
		end
	end

	// Both read ports are combinational, so data is valid in the access cycle.
	assign port.rdestData = regs[port.rdestLoc];
	assign port.rsrcData  = regs[port.rsrcLoc];

	assign KeyCode = regs[keyReg]; // Tap for the keyboard code register.

endmodule

// ==== hw/portArbiter.sv ====
`timescale 1ns/1ps

module portArbiter (
	input  logic        Clk,
	input  logic        rst,
	regPortIf.arbiter   execPort,
	regPortIf.arbiter   loadPort,
	regPortIf.requester filePort
);

	logic execLast; // Set when the execution unit was served last.
	logic execGnt;
	logic loadGnt;

	// A lone requester always wins. On a tie the side not served last goes first,
	// which gives exec the first turn after reset.
	always_comb begin
		execGnt = filePort.gnt && execPort.req && (!loadPort.req || !execLast);
		loadGnt = filePort.gnt && loadPort.req && !execGnt;
	end

	always_ff @(posedge Clk) begin
		if (!rst) begin
			execLast <= 1'b0;
		end else if (execGnt) begin
			execLast <= 1'b1;
		end else if (loadGnt) begin
			execLast <= 1'b0;
		end
	end

	assign execPort.gnt = execGnt;
	assign loadPort.gnt = loadGnt;

	assign filePort.req = execPort.req || loadPort.req;

	always_comb begin
		if (loadGnt) begin
			filePort.rdestLoc = loadPort.rdestLoc;
			filePort.rsrcLoc  = loadPort.rsrcLoc;
			filePort.load     = loadPort.load;
		end else begin
			filePort.rdestLoc = execPort.rdestLoc;
			filePort.rsrcLoc  = execPort.rsrcLoc;
			filePort.load     = execPort.load;
		end
	end

	// No write may reach the file without a grant.
	assign filePort.we = (execGnt && execPort.we) || (loadGnt && loadPort.we);

	// Read data goes back to both sides. Only the granted one samples it.
	assign execPort.rdestData = filePort.rdestData;
	assign execPort.rsrcData  = filePort.rsrcData;
	assign loadPort.rdestData = filePort.rdestData;
	assign loadPort.rsrcData  = filePort.rsrcData;

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
	input  logic            Clk,
	input  logic            rst,
	input  logic            opValid,
	output logic            opReady,
	input  aluPkg::opcode_t opCode,
	input  regPkg::regIdx_t opDest,
	input  regPkg::regIdx_t opSrc,
	output logic            opDone,
	regPortIf.requester     port
);

	typedef enum logic {
		Idle,
		Access
	} state_t;

	state_t          state;
	aluPkg::opcode_t code;
	regPkg::regIdx_t dest;
	regPkg::regIdx_t src;
	regPkg::word_t   result;
	logic            writeOp;

	always_ff @(posedge Clk) begin
		if (!rst) begin
			state <= Idle;
		end else begin
			case (state)
				Idle: if (opValid) state <= Access;
				Access: if (port.gnt) state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	// The op fields are payload and only change on acceptance.
	always_ff @(posedge Clk) begin
		if (opValid && opReady) begin
			code <= opCode;
			dest <= opDest;
			src  <= opSrc;
		end
	end

	// The operands arrive combinationally in the grant cycle.
	always_comb begin
		result  = port.rdestData;
		writeOp = 1'b1;
		case (code)
			aluPkg::OpAdd: result = port.rdestData + port.rsrcData;
			aluPkg::OpSub: result = port.rdestData - port.rsrcData;
			aluPkg::OpAnd: result = port.rdestData & port.rsrcData;
			aluPkg::OpOr:  result = port.rdestData | port.rsrcData;
			aluPkg::OpXor: result = port.rdestData ^ port.rsrcData;
			aluPkg::OpMov: result = port.rsrcData;
			default:       writeOp = 1'b0; // Reserved codes leave the file untouched.
		endcase
	end

	assign opReady = (state == Idle);

	assign port.req      = (state == Access);
	assign port.rdestLoc = dest;
	assign port.rsrcLoc  = src;
	assign port.load     = result;
	assign port.we       = (state == Access) && writeOp;

	assign opDone = (state == Access) && port.gnt; // Same cycle as the write.

endmodule

// ==== hw/loadUnit.sv ====
`timescale 1ns/1ps

module loadUnit (
	input  logic            Clk,
	input  logic            rst,
	input  logic            cmdValid,
	output logic            cmdReady,
	input  logic            cmdWrite,
	input  regPkg::regIdx_t cmdReg,
	input  regPkg::word_t   cmdData,
	output logic            rspValid,
	input  logic            rspReady,
	output regPkg::word_t   rspData,
	regPortIf.requester     port
);

	typedef enum logic [1:0] {
		Idle,
		Access,
		Respond
	} state_t;

	state_t          state;
	logic            write;
	regPkg::regIdx_t target;
	regPkg::word_t   data;

	always_ff @(posedge Clk) begin
		if (!rst) begin
			state <= Idle;
		end else begin
			case (state)
				Idle: begin
					if (cmdValid) begin
						state <= Access;
					end
				end
				Access: begin
					if (port.gnt) begin
						state <= write ? Idle : Respond;
					end
				end
				Respond: begin
					if (rspReady) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (cmdValid && cmdReady) begin
			write  <= cmdWrite;
			target <= cmdReg;
			data   <= cmdData;
		end
	end

	// Readback data is captured in the grant cycle and held until consumed.
	always_ff @(posedge Clk) begin
		if (state == Access && port.gnt && !write) begin
			rspData <= port.rdestData;
		end
	end

	// A pending response keeps new commands out.
	assign cmdReady = (state == Idle);
	assign rspValid = (state == Respond);

	assign port.req      = (state == Access);
	assign port.rdestLoc = target;
	assign port.rsrcLoc  = target;
	assign port.we       = (state == Access) && write;
	assign port.load     = data;

endmodule

// ==== hw/datapathTop.sv ====
`timescale 1ns/1ps

module datapathTop #(
	parameter regPkg::regIdx_t keyReg = 4'd9
) (
	input  logic            Clk,
	input  logic            rst,

	input  logic            opValid,
	output logic            opReady,
	input  aluPkg::opcode_t opCode,
	input  regPkg::regIdx_t opDest,
	input  regPkg::regIdx_t opSrc,
	output logic            opDone,

	input  logic            cmdValid,
	output logic            cmdReady,
	input  logic            cmdWrite,
	input  regPkg::regIdx_t cmdReg,
	input  regPkg::word_t   cmdData,

	output logic            rspValid,
	input  logic            rspReady,
	output regPkg::word_t   rspData,

	output regPkg::word_t   KeyCode
);

	regPortIf execPort ();
	regPortIf loadPort ();
	regPortIf filePort ();

	// The register file serves one access every cycle.
	assign filePort.gnt = filePort.req;

	execUnit execUnit_i (
		.Clk     (Clk),
		.rst     (rst),
		.opValid (opValid),
		.opReady (opReady),
		.opCode  (opCode),
		.opDest  (opDest),
		.opSrc   (opSrc),
		.opDone  (opDone),
		.port    (execPort.requester)
	);

	loadUnit loadUnit_i (
		.Clk      (Clk),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmdWrite (cmdWrite),
		.cmdReg   (cmdReg),
		.cmdData  (cmdData),
		.rspValid (rspValid),
		.rspReady (rspReady),
		.rspData  (rspData),
		.port     (loadPort.requester)
	);

	portArbiter portArbiter_i (
		.Clk      (Clk),
		.rst      (rst),
		.execPort (execPort.arbiter),
		.loadPort (loadPort.arbiter),
		.filePort (filePort.requester)
	);

	RegFile #(
		.keyReg (keyReg)
	) regFile_i (
		.Clk     (Clk),
		.rst     (rst),
		.port    (filePort.regFile),
		.KeyCode (KeyCode)
	);

endmodule

// ==== tb/datapath_assertions.sv ====
`timescale 1ns/1ps

module datapath_assertions (
	input logic Clk,
	input logic rst,
	input logic execReq,
	input logic loadReq,
	input logic execGnt,
	input logic loadGnt,
	input logic fileWe
);

	int failCount = 0;

	assert property (@(posedge Clk) disable iff (!rst) !(execGnt && loadGnt))
		else begin
			failCount++;
			$error("Both requesters were granted in the same cycle.");
		end

	assert property (@(posedge Clk) disable iff (!rst) execGnt |-> execReq)
		else begin
			failCount++;
			$error("The execution unit was granted without a request.");
		end

	assert property (@(posedge Clk) disable iff (!rst) loadGnt |-> loadReq)
		else begin
			failCount++;
			$error("The load unit was granted without a request.");
		end

	// The file must never see a write that was not granted.
	assert property (@(posedge Clk) disable iff (!rst) fileWe |-> (execGnt || loadGnt))
		else begin
			failCount++;
			$error("Register file write without a grant.");
		end

endmodule

bind portArbiter datapath_assertions assertions_i (
	.Clk     (Clk),
	.rst     (rst),
	.execReq (execPort.req),
	.loadReq (loadPort.req),
	.execGnt (execGnt),
	.loadGnt (loadGnt),
	.fileWe  (filePort.we)
);

// ==== tb/datapathTb.sv ====
`timescale 1ns/1ps

module datapathTb;

	localparam int ResetCycles = 16;
	localparam int AluOps      = 24;
	localparam int ConcOps     = 32;
	localparam int ConcCmds    = 32;
	// Counts the transactions of each phase in the order the stimulus runs them.
	localparam int TxCount = 16 + 32 + 6 + 2 * AluOps + 18 + 3 + ConcOps + ConcCmds + 8;
	localparam int WatchdogCycles = ResetCycles + 40 * TxCount;

	logic            Clk = 1'b0;
	logic            rst;
	logic            opValid, opReady, opDone;
	aluPkg::opcode_t opCode;
	regPkg::regIdx_t opDest, opSrc;
	logic            cmdValid, cmdReady, cmdWrite;
	regPkg::regIdx_t cmdReg;
	regPkg::word_t   cmdData;
	logic            rspValid, rspReady;
	regPkg::word_t   rspData, KeyCode;

	regPkg::word_t   model [regPkg::NumRegs];
	regPkg::word_t   expQ [$];
	logic [31:0]     seed = 32'd49;
	logic            randomHold = 1'b0; // Set while rspReady is randomized.
	logic            keyPending = 1'b0;
	logic            heldValid = 1'b0;
	regPkg::word_t   heldData;
	aluPkg::opcode_t pendCode;
	regPkg::regIdx_t pendDest, pendSrc;
	logic [15:0]     opsAccepted = '0;
	logic [15:0]     doneCount = '0;

	datapathTop datapathTop_i (.*);

	always #4 Clk = ~Clk;

	function automatic regPkg::word_t randWord();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[30:15];
	endfunction

	function automatic regPkg::regIdx_t randReg();
		regPkg::word_t r;
		r = randWord();
		return r[3:0];
	endfunction

	// Expected Rdest after an op. Reserved codes keep Rdest as it is.
	function automatic regPkg::word_t refAlu(input aluPkg::opcode_t code,
		input regPkg::word_t a, input regPkg::word_t b);
		case (code)
			aluPkg::OpAdd: return a + b;
			aluPkg::OpSub: return a - b;
			aluPkg::OpAnd: return a & b;
			aluPkg::OpOr:  return a | b;
			aluPkg::OpXor: return a ^ b;
			aluPkg::OpMov: return b;
			default:       return a;
		endcase
	endfunction

	task automatic stopOnFailure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			stopOnFailure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic sendCmd(input logic write, input regPkg::regIdx_t idx, input regPkg::word_t data);
		@(posedge Clk);
		#1;
		cmdValid = 1'b1;
		cmdWrite = write;
		cmdReg   = idx;
		cmdData  = data;
		@(posedge Clk);
		while (!cmdReady) begin
			@(posedge Clk);
		end
		#1;
		cmdValid = 1'b0;
	endtask

	task automatic sendOp(input aluPkg::opcode_t code, input regPkg::regIdx_t dest,
		input regPkg::regIdx_t src);
		@(posedge Clk);
		#1;
		opValid = 1'b1;
		opCode  = code;
		opDest  = dest;
		opSrc   = src;
		@(posedge Clk);
		while (!opReady) begin
			@(posedge Clk);
		end
		#1;
		opValid = 1'b0;
	endtask

	// Returns on an edge once both units are idle and every response is consumed.
	task automatic waitIdle();
		@(posedge Clk);
		while (!opReady || !cmdReady || rspValid || expQ.size() != 0) begin
			@(posedge Clk);
		end
	endtask

	always @(posedge Clk) begin
		#1;
		rspReady = randomHold ? randWord() > 16'h6000 : 1'b1;
	end

	// Compare process. Inputs change 1 ns after the edge, so edge samples are stable.
	always @(posedge Clk) begin
		if (rst) begin
			if (keyPending) begin
				checkValue("KeyCode", KeyCode, model[9]);
			end
			keyPending = 1'b0;
			if (heldValid) begin
				checkValue("rspData (held)", rspData, heldData);
			end
			if (rspValid && rspReady) begin
				if (expQ.size() == 0) begin
					stopOnFailure("A response arrived with no read command outstanding.");
				end else begin
					checkValue("rspData", rspData, expQ.pop_front());
				end
			end
			heldValid = rspValid && !rspReady;
			heldData  = rspData;
			if (cmdValid && cmdReady) begin
				if (cmdWrite) begin
					model[cmdReg] = cmdData;
				end else begin
					expQ.push_back(model[cmdReg]);
				end
			end
			if (opValid && opReady) begin
				pendCode = opCode;
				pendDest = opDest;
				pendSrc  = opSrc;
				opsAccepted++;
			end
			if (opDone) begin
				model[pendDest] = refAlu(pendCode, model[pendDest], model[pendSrc]);
				doneCount++;
				keyPending = 1'b1; // KeyCode shows the write after this edge.
			end
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge Clk);
		stopOnFailure("Watchdog expired: the DUT stopped responding and the run hung.");
	end

	initial begin
		regPkg::regIdx_t dest;
		regPkg::regIdx_t src;
		rst = 1'b0;
		opValid = 1'b0;
		opCode = '0;
		opDest = '0;
		opSrc = '0;
		cmdValid = 1'b0;
		cmdWrite = 1'b0;
		cmdReg = '0;
		cmdData = '0;
		rspReady = 1'b1;
		for (int i = 0; i < regPkg::NumRegs; i++) begin
			model[i] = '0;
		end
		repeat (ResetCycles) @(posedge Clk);
		#1;
		rst = 1'b1;
		@(posedge Clk);
		checkValue("KeyCode", KeyCode, 16'h0000);
		checkValue("opReady", opReady, 16'h0001);
		checkValue("cmdReady", cmdReady, 16'h0001);
		checkValue("rspValid", rspValid, 16'h0000);
		checkValue("opDone", opDone, 16'h0000);

		for (int i = 0; i < regPkg::NumRegs; i++) begin
			sendCmd(1'b0, i[3:0], '0);
		end
		waitIdle();

		for (int i = 0; i < regPkg::NumRegs; i++) begin
			sendCmd(1'b1, i[3:0], randWord());
		end
		for (int i = 0; i < regPkg::NumRegs; i++) begin
			sendCmd(1'b0, i[3:0], '0);
		end
		waitIdle();
		checkValue("KeyCode", KeyCode, model[9]);

		// Both directions of 16-bit wraparound.
		sendCmd(1'b1, 4'd3, 16'hFFFF);
		sendCmd(1'b1, 4'd4, 16'h0002);
		sendOp(aluPkg::OpAdd, 4'd3, 4'd4);
		waitIdle();
		sendCmd(1'b0, 4'd3, '0);
		sendOp(aluPkg::OpSub, 4'd3, 4'd4);
		waitIdle();
		sendCmd(1'b0, 4'd3, '0);
		waitIdle();

		for (int i = 0; i < AluOps; i++) begin
			dest = randReg();
			src  = (i % 4 == 0) ? dest : randReg();
			sendOp(aluPkg::opcode_t'(i % 6), dest, src);
			waitIdle();
			sendCmd(1'b0, dest, '0);
			waitIdle();
		end

		sendOp(3'd6, 4'd9, 4'd1);
		sendOp(3'd7, 4'd2, 4'd9);
		waitIdle();
		for (int i = 0; i < regPkg::NumRegs; i++) begin
			sendCmd(1'b0, i[3:0], '0);
		end
		waitIdle();

		sendCmd(1'b1, 4'd9, 16'hA55A);
		waitIdle();
		checkValue("KeyCode", KeyCode, model[9]);
		sendOp(aluPkg::OpMov, 4'd9, 4'd4);
		waitIdle();
		sendCmd(1'b0, 4'd9, '0);
		waitIdle();

		// Ops stay on registers 8 to 15 and commands on 0 to 7.
		randomHold = 1'b1;
		fork
			for (int i = 0; i < ConcOps; i++) begin
				sendOp(aluPkg::opcode_t'(randWord()), randReg() | 4'd8, randReg() | 4'd8);
			end
			for (int i = 0; i < ConcCmds; i++) begin
				sendCmd(i[0] == 1'b0, randReg() & 4'd7, randWord());
			end
		join
		randomHold = 1'b0;
		waitIdle();
		for (int i = 8; i < regPkg::NumRegs; i++) begin
			sendCmd(1'b0, i[3:0], '0);
		end
		waitIdle();
		checkValue("opDone count", doneCount, opsAccepted);

		if (datapathTop_i.portArbiter_i.assertions_i.failCount == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stopOnFailure("A bound assertion on the port arbiter failed.");
		end
	end

endmodule

// ==== datapath.f ====
hw/regPkg.sv
hw/aluPkg.sv
hw/regPortIf.sv
hw/RegFile.sv
hw/portArbiter.sv
hw/execUnit.sv
hw/loadUnit.sv
hw/datapathTop.sv
tb/datapath_assertions.sv
tb/datapathTb.sv

// ==== Bender.yml ====
package:
  name: datapath

sources:
  - files:
      - hw/regPkg.sv
      - hw/aluPkg.sv
      - hw/regPortIf.sv
      - hw/RegFile.sv
      - hw/portArbiter.sv
      - hw/execUnit.sv
      - hw/loadUnit.sv
      - hw/datapathTop.sv

  - target: test
    files:
      - tb/datapath_assertions.sv
      - tb/datapathTb.sv
